// File: patch_match_trace.txt
# W bus_addr lane byte | R bus_addr half expected_dat | all fields hex
# M first count pix0 pix1 pix2 pix3 pix4 best_addr best_sad
W 00000210 0 64
W 00000210 1 40
W 00000210 2 06
W 00000210 3 4b
W 00000210 4 20
W 00000210 5 43
W 00000210 6 1f
W 00000210 7 a5
R 00000210 0 4b064064
R 00000210 1 001f4320
W 00000211 0 ff
W 00000211 1 07
W 00000211 2 00
W 00000211 3 5a
W 00000211 4 47
W 00000211 5 52
W 00000211 6 05
R 00000211 0 5a0007ff
W 00000211 3 00
R 00000211 0 000007ff
R 00000211 1 00055247
W 00000212 0 6e
W 00000212 1 40
W 00000212 2 06
W 00000212 3 4b
W 00000212 4 20
W 00000212 5 43
W 00000212 6 1f
R 00000212 0 4b06406e
R 00000212 1 001f4320
W 00000010 0 ff
W 00000410 1 ff
R 00000010 0 00000000
R 00000410 1 00000000
R 00000210 0 4b064064
R 00000400 0 00000000
M 010 3 069 0c8 12c 190 1f4 010 0005
M 011 2 06e 0c8 12c 190 1f4 012 0000
M 011 1 7f0 001 400 123 055 011 0010
M 010 3 7f0 001 400 123 055 011 0010

// File: list.f
+incdir+.
patch_match_pkg.sv
wb_patch_port.sv
query_patch_ram.sv
patch_sad_matcher.sv
patch_match_top.sv
tb_patch_match.sv

// File: Makefile
SIM      = verilator
VFLAGS   = --binary --timing -Wno-fatal -j 0
TOP      = tb_patch_match
FILELIST = list.f

OBJ_DIR  = obj_dir
SIM_BIN  = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
TRACE    = patch_match_trace.txt
SRCS     = $(shell grep -v '^+' $(FILELIST)) patch_match_macros.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_patch_match.sv
`timescale 1ns/1ps

module tb_patch_match;
    import patch_match_pkg::*;

    localparam int ACK_LIMIT = 16;      // Cycles allowed for one bus ack

    logic       clk;
    logic       arst_n;
    wb_req_t    wb_req;
    wb_rsp_t    wb_rsp;
    logic       start;
    match_cmd_t cmd;
    logic       busy;
    logic       done;
    match_res_t res;

    integer     seed;
    int         errors;
    int         timeouts;
    int         checks;
    logic       stop;                   // Trace is abandoned after a timeout

    patch_match_top i_dut (
        .clk_i    (clk),
        .arst_n_i (arst_n),
        .wb_i     (wb_req),
        .wb_o     (wb_rsp),
        .start_i  (start),
        .cmd_i    (cmd),
        .busy_o   (busy),
        .done_o   (done),
        .res_o    (res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_wb_dat(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input ram_addr_t got, input ram_addr_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got 0x%03h, expected 0x%03h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_sad(input string name, input sad_t got, input sad_t exp);
        checks++;
        if (got !== exp) begin
            $display("Fail %s: got 0x%04h, expected 0x%04h", name, got, exp);
            errors++;
        end
    endtask

    // One classic cycle, ack expected in the cycle after the request
    task automatic bus_cycle(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             output logic [31:0] rdat);
        int   n;
        logic acked;
        n     = 0;
        acked = 1'b0;
        rdat  = '0;
        @(posedge clk);
        wb_req.cyc <= 1'b1;
        wb_req.stb <= 1'b1;
        wb_req.we  <= we;
        wb_req.sel <= 4'hf;
        wb_req.adr <= adr;
        wb_req.dat <= dat;
        while (!acked && n < ACK_LIMIT) begin
            @(negedge clk);
            n++;
            if (wb_rsp.ack) begin
                acked = 1'b1;
                rdat  = wb_rsp.dat;
            end
        end
        if (!acked) begin
            $display("Timeout: no ack for bus address 0x%08h", adr);
            timeouts++;
            stop = 1'b1;
        end else if (n != 2) begin
            $display("Ack came %0d cycles after the request instead of 1", n - 1);
            errors++;
        end
    endtask

    // Random idle time between bus cycles, zero keeps them back to back
    task automatic bus_gap();
        int gap;
        gap = $random(seed) & 3;
        if (gap != 0) begin
            @(posedge clk);
            wb_req.cyc <= 1'b0;
            wb_req.stb <= 1'b0;
            @(negedge clk);
            if (wb_rsp.ack) begin
                $display("Ack stayed high for a second cycle");
                errors++;
            end
            repeat (gap - 1) @(posedge clk);
        end
    endtask

    task automatic run_match(input ram_addr_t first, input match_cnt_t count,
                             input patch_t target, input ram_addr_t exp_addr,
                             input sad_t exp_sad);
        match_cmd_t req;
        match_cmd_t other;
        int         c;
        int         limit;
        logic       seen;
        req.target   = target;
        req.first    = first;
        req.count    = count;
        other.target = ~target;         // Would change the result if it were taken
        other.first  = first + 1'b1;
        other.count  = count;
        c     = 0;
        limit = int'(count) + 8;
        seen  = 1'b0;
        @(posedge clk);
        start      <= 1'b1;
        cmd        <= req;
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        while (!seen && c < limit) begin
            @(negedge clk);
            if (busy !== (c != 0)) begin
                $display("busy_o is %b %0d cycles after start", busy, c);
                errors++;
            end
            if (done) begin
                seen = 1'b1;
            end else begin
                @(posedge clk);
                c++;
                start <= (c == 2);      // Second start arrives while busy
                if (c == 2) begin
                    cmd <= other;
                end
            end
        end
        if (!seen) begin
            $display("Timeout: done_o never rose for the match at 0x%03h", first);
            timeouts++;
            stop = 1'b1;
        end else begin
            if (c != int'(count) + 2) begin
                $display("done_o rose %0d cycles after start, expected %0d", c, int'(count) + 2);
                errors++;
            end
            check_addr("res_o.best_addr", res.best_addr, exp_addr);
            check_sad("res_o.best_sad", res.best_sad, exp_sad);
            repeat (3) @(negedge clk);
            if (done || busy) begin
                $display("done_o or busy_o still high after the match ended");
                errors++;
            end
            check_addr("res_o.best_addr held", res.best_addr, exp_addr);
            check_sad("res_o.best_sad held", res.best_sad, exp_sad);
        end
    endtask

    initial begin
        integer           fd;
        int               n;
        logic [7:0]       kind;
        logic [8*160-1:0] line_buf;
        logic [31:0]      adr;
        logic [31:0]      rdat;
        logic [31:0]      exp_dat;
        logic [2:0]       lane;
        logic [7:0]       bval;
        logic             half;
        ram_addr_t        m_first;
        match_cnt_t       m_count;
        pixel_t           pix [5];
        patch_t           target;
        ram_addr_t        exp_addr;
        sad_t             exp_sad;
        seed     = 32'hb033;
        errors   = 0;
        timeouts = 0;
        checks   = 0;
        stop     = 1'b0;
        arst_n   = 1'b0;
        wb_req   = '0;
        start    = 1'b0;
        cmd      = '0;
        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (wb_rsp.ack || busy || done) begin
            $display("Outputs not idle after reset");
            errors++;
        end
        check_addr("res_o.best_addr", res.best_addr, '0);
        check_sad("res_o.best_sad", res.best_sad, '0);

        fd = $fopen("patch_match_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open patch_match_trace.txt");
            errors++;
        end else begin
            while (!stop && !$feof(fd)) begin
                n = $fscanf(fd, " %c", kind);
                if (n == 1) begin
                    case (kind)
                        "#": n = $fgets(line_buf, fd);
                        "W": begin
                            n = $fscanf(fd, " %h %h %h", adr, lane, bval);
                            bus_cycle(1'b1, adr, {18'h0, lane, 3'b000, bval}, rdat);
                            bus_gap();
                        end
                        "R": begin
                            n = $fscanf(fd, " %h %h %h", adr, half, exp_dat);
                            bus_cycle(1'b0, adr, {20'h0, half, 11'h0}, rdat);
                            check_wb_dat("wb_o.dat", rdat, exp_dat);
                            bus_gap();
                        end
                        "M": begin
                            n = $fscanf(fd, " %h %h %h %h %h %h %h %h %h", m_first, m_count,
                                        pix[0], pix[1], pix[2], pix[3], pix[4],
                                        exp_addr, exp_sad);
                            for (int i = 0; i < 5; i++) begin
                                target[i] = pix[i];
                            end
                            run_match(m_first, m_count, target, exp_addr, exp_sad);
                        end
                        default: begin
                            $display("Unknown record type '%c' in the trace", kind);
                            errors++;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        @(posedge clk);
        wb_req.cyc <= 1'b0;
        wb_req.stb <= 1'b0;
        if (checks < 10) begin
            $display("Too few checks were run, the trace looks incomplete");
            errors++;
        end
        $display("Errors: %0d, timeouts: %0d, checks: %0d", errors, timeouts, checks);
        if (errors == 0 && timeouts == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

// File: patch_match_top.sv
`timescale 1ns/1ps

module patch_match_top (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    // Host bus
    input  patch_match_pkg::wb_req_t    wb_i,
    output patch_match_pkg::wb_rsp_t    wb_o,
    // Matcher command
    input  logic                        start_i,
    input  patch_match_pkg::match_cmd_t cmd_i,
    output logic                        busy_o,
    output logic                        done_o,
    output patch_match_pkg::match_res_t res_o
);
    import patch_match_pkg::*;

    // Port 0, Wishbone side
    logic       cs0;
    logic       we0;
    ram_addr_t  addr0;
    byte_mask_t wmask;
    ram_word_t  wdata0;
    ram_word_t  rdata0;

    // Port 1, matcher side
    logic       cs1;
    ram_addr_t  addr1;
    ram_word_t  rdata1;

    wb_patch_port i_wb_port (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .wb_i     (wb_i),
        .rdata0_i (rdata0),
        .wb_o     (wb_o),
        .cs0_o    (cs0),
        .we0_o    (we0),
        .addr0_o  (addr0),
        .wmask_o  (wmask),
        .wdata0_o (wdata0)
    );

    query_patch_ram i_ram (
        .clk_i    (clk_i),
        .cs0_i    (cs0),
        .we0_i    (we0),
        .addr0_i  (addr0),
        .wmask_i  (wmask),
        .wdata0_i (wdata0),
        .rdata0_o (rdata0),
        .cs1_i    (cs1),
        .addr1_i  (addr1),
        .rdata1_o (rdata1)
    );

    patch_sad_matcher i_matcher (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .start_i  (start_i),
        .cmd_i    (cmd_i),
        .rdata1_i (rdata1),
        .cs1_o    (cs1),
        .addr1_o  (addr1),
        .busy_o   (busy_o),
        .done_o   (done_o),
        .res_o    (res_o)
    );

endmodule

// File: patch_sad_matcher.sv
`timescale 1ns/1ps
`include "patch_match_macros.svh"

module patch_sad_matcher (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  logic                        start_i,
    input  patch_match_pkg::match_cmd_t cmd_i,
    input  patch_match_pkg::ram_word_t  rdata1_i,
    output logic                        cs1_o,
    output patch_match_pkg::ram_addr_t  addr1_o,
    output logic                        busy_o,
    output logic                        done_o,
    output patch_match_pkg::match_res_t res_o
);
    import patch_match_pkg::*;

    matcher_state_e state_q;
    match_cnt_t     left_q;     // Addresses still to issue
    logic           drain_q;
    logic           accept;

    ram_addr_t      addr_q;
    patch_t         target_q;

    // Words in flight
    logic           v1_q;       // Memory data valid this cycle
    logic           v2_q;       // SAD ready for compare
    ram_addr_t      a1_q;
    ram_addr_t      a2_q;
    sad_t           sad_d;
    sad_t           sad_q;

    logic           first_q;    // No word compared yet for this command
    logic           upd;
    match_res_t     best_q;

    assign accept = start_i && (state_q == IDLE);   // Starts while busy are dropped

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state_q <= IDLE;
            left_q  <= '0;
            drain_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= SWEEP;
                        left_q  <= cmd_i.count;
                    end
                end
                SWEEP: begin
                    left_q <= left_q - 1'b1;
                    if (left_q == match_cnt_t'(1)) begin
                        state_q <= DRAIN;
                        drain_q <= 1'b0;
                    end
                end
                DRAIN: begin
                    // Two cycles for the last read and its compare
                    if (drain_q) begin
                        state_q <= IDLE;
                    end
                    drain_q <= 1'b1;
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_q   <= cmd_i.first;
            target_q <= cmd_i.target;
        end else if (state_q == SWEEP) begin
            addr_q <= addr_q + 1'b1;
        end
        a1_q  <= addr_q;
        a2_q  <= a1_q;
        sad_q <= sad_d;
    end

    // Sum of absolute pixel differences of the returning word
    always_comb begin
        patch_t cand;
        pixel_t diff;
        cand  = rdata1_i[$bits(patch_t)-1:0];
        sad_d = '0;
        for (int p = 0; p < `PM_PATCH_SIZE; p++) begin
            diff  = (cand[p] > target_q[p]) ? cand[p] - target_q[p] : target_q[p] - cand[p];
            sad_d = sad_d + sad_t'(diff);
        end
    end

    // Strictly smaller only, so the lower address keeps a tie
    assign upd = v2_q && (first_q || (sad_q < best_q.best_sad));

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            v1_q    <= 1'b0;
            v2_q    <= 1'b0;
            first_q <= 1'b0;
            best_q  <= '0;
        end else begin
            v1_q <= cs1_o;
            v2_q <= v1_q;
            if (accept) begin
                first_q <= 1'b1;
            end else if (upd) begin
                first_q <= 1'b0;
            end
            if (upd) begin
                best_q.best_addr <= a2_q;
                best_q.best_sad  <= sad_q;
            end
        end
    end

    // Last compare is forwarded so the result is final while done is high
    always_comb begin
        res_o = best_q;
        if (upd) begin
            res_o.best_addr = a2_q;
            res_o.best_sad  = sad_q;
        end
    end

    assign cs1_o   = (state_q == SWEEP);
    assign addr1_o = addr_q;
    assign busy_o  = (state_q != IDLE);
    assign done_o  = (state_q == DRAIN) && drain_q;

endmodule

// File: query_patch_ram.sv
`timescale 1ns/1ps
`include "patch_match_macros.svh"

module query_patch_ram (
    input  logic                        clk_i,
    // Port 0, read or write
    input  logic                        cs0_i,
    input  logic                        we0_i,
    input  patch_match_pkg::ram_addr_t  addr0_i,
    input  patch_match_pkg::byte_mask_t wmask_i,
    input  patch_match_pkg::ram_word_t  wdata0_i,
    output patch_match_pkg::ram_word_t  rdata0_o,
    // Port 1, read only
    input  logic                        cs1_i,
    input  patch_match_pkg::ram_addr_t  addr1_i,
    output patch_match_pkg::ram_word_t  rdata1_o
);
    import patch_match_pkg::*;

    ram_word_t mem [`PM_DEPTH];

    // Byte-masked write
    always_ff @(posedge clk_i) begin
        if (cs0_i && we0_i) begin
            for (int b = 0; b < `PM_LANES; b++) begin
                if (wmask_i[b]) begin
                    mem[addr0_i][b*8 +: 8] <= wdata0_i[b*8 +: 8];
                end
            end
        end
    end

    // Port 0 read, data valid the next cycle
    always_ff @(posedge clk_i) begin
        if (cs0_i && !we0_i) begin
            rdata0_o <= mem[addr0_i];
        end
    end

    // Port 1 read sees the old word on a same-cycle write
    always_ff @(posedge clk_i) begin
        if (cs1_i) begin
            rdata1_o <= mem[addr1_i];
        end
    end

endmodule

// File: wb_patch_port.sv
`timescale 1ns/1ps
`include "patch_match_macros.svh"

module wb_patch_port (
    input  logic                        clk_i,
    input  logic                        arst_n_i,
    input  patch_match_pkg::wb_req_t    wb_i,
    input  patch_match_pkg::ram_word_t  rdata0_i,
    output patch_match_pkg::wb_rsp_t    wb_o,
    output logic                        cs0_o,
    output logic                        we0_o,
    output patch_match_pkg::ram_addr_t  addr0_o,
    output patch_match_pkg::byte_mask_t wmask_o,
    output patch_match_pkg::ram_word_t  wdata0_o
);
    import patch_match_pkg::*;

    logic [31:0] word_addr;   // Bus address relative to the memory window
    logic        in_win;
    logic        req;
    logic [2:0]  lane;
    logic        ack_q;
    logic        rd_q;        // In-window read waiting for memory data
    logic        half_q;      // Upper half requested
    logic [31:0] rd_dat;

    // A request held over its ack cycle must not access the memory twice
    assign req = wb_i.cyc & wb_i.stb & ~ack_q;

    // Addresses below the base wrap around and land out of window too
    assign word_addr = wb_i.adr - `PM_WB_BASE;
    assign in_win    = word_addr < `PM_DEPTH;

    // Lane select travels in the data word, sel is not decoded
    assign lane = wb_i.dat[13:11];

    assign cs0_o   = req & in_win;
    assign we0_o   = wb_i.we;
    assign addr0_o = word_addr[`PM_ADDR_WIDTH-1:0];

    // One-hot mask and the byte moved into its lane
    assign wmask_o  = byte_mask_t'(1) << lane;
    assign wdata0_o = ram_word_t'(wb_i.dat[7:0]) << {lane, 3'b000};

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_q  <= 1'b0;
            rd_q   <= 1'b0;
            half_q <= 1'b0;
        end else begin
            ack_q <= req;                            // Acks out-of-window accesses as well
            rd_q  <= req & in_win & ~wb_i.we;
            if (req) begin
                half_q <= wb_i.dat[11];
            end
        end
    end

    // Read data is steered in the cycle the memory answers
    always_comb begin
        if (!rd_q) begin
            rd_dat = '0;                             // Writes and out-of-window reads
        end else if (half_q) begin
            rd_dat = 32'(rdata0_i[$bits(patch_t)-1:32]);
        end else begin
            rd_dat = rdata0_i[31:0];
        end
    end

    assign wb_o.ack = ack_q;
    assign wb_o.dat = rd_dat;

endmodule

// File: patch_match_pkg.sv
`include "patch_match_macros.svh"

package patch_match_pkg;

    typedef logic [`PM_DATA_WIDTH-1:0] pixel_t;
    typedef pixel_t [`PM_PATCH_SIZE-1:0] patch_t;     // Pixel 0 in the low bits
    typedef logic [`PM_WORD_WIDTH-1:0] ram_word_t;
    typedef logic [`PM_ADDR_WIDTH-1:0] ram_addr_t;
    typedef logic [`PM_LANES-1:0] byte_mask_t;
    typedef logic [`PM_SAD_WIDTH-1:0] sad_t;
    typedef logic [`PM_ADDR_WIDTH:0] match_cnt_t;     // Holds 1 to PM_DEPTH

    // Wishbone classic, master to slave
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [3:0]  sel;
        logic [31:0] adr;
        logic [31:0] dat;
    } wb_req_t;

    // Wishbone classic, slave to master
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    typedef struct packed {
        patch_t     target;
        ram_addr_t  first;
        match_cnt_t count;
    } match_cmd_t;

    typedef struct packed {
        ram_addr_t best_addr;
        sad_t      best_sad;
    } match_res_t;

    typedef enum logic [1:0] {
        IDLE,
        SWEEP,
        DRAIN
    } matcher_state_e;

endpackage

// File: patch_match_macros.svh
`ifndef PATCH_MATCH_MACROS_SVH
`define PATCH_MATCH_MACROS_SVH

// Patch geometry
`define PM_DATA_WIDTH 11           // Bits per pixel
`define PM_PATCH_SIZE 5            // Pixels per query patch

// Patch memory
`define PM_ADDR_WIDTH 9
`define PM_DEPTH      512
`define PM_WORD_WIDTH 64           // Patch padded up to a whole number of bytes
`define PM_LANES      8            // Byte lanes per word

// Worst case SAD is 5 * 2047 = 10235
`define PM_SAD_WIDTH  14

// Wishbone word address that maps to memory word 0
`define PM_WB_BASE    32'h0000_0200

`endif
